// ==== verification/gb_cpu_patterns.mem ====
// Program image from 0000, trigger records at 1000 (count, then write count and irq mask),
// expected writes at 2000 (count, then addr hi, addr lo, data)
@0000
06 3A 0E C5 3E 0F 80 E0 80 91 E0 81 A0 E0 82 B1  // Loads, ADD, SUB, AND, OR
E0 83 A8 E0 84 3C 04 80 E0 85 3E 80 87 28 02 E0  // XOR, INC, then JR Z
87 E0 86 30 02 E0 88 E0 89 20 02 38 02 E0 8A E0  // JR NC, JR NZ, JR C
8B C3 00 01                                      // JP 0100
@0040
3E B0 E0 94 D9                                   // Handler 0
@0048
3E B1 E0 92 D9                                   // Handler 1
@0050
3E B2 E0 93 D9                                   // Handler 2
@0100
3E 5A E0 8C 18 10 E0 8D                          // Store, JR over a stray store
@0116
26 C0 2E 12 3E A7 77 3E 00 7E E0 8E F3 3E 1F E0  // (HL) round trip, DI, IE write
FF 3E 00 F0 FF E0 8F 06 E0 04 20 FD F0 0F E0 90  // IE read back, delay loop, IF read
AF E0 0F FB 3E 77 E0 91 18 FE                    // Clear IF, EI, spin at 013E
@1000
02 0F 01 12 06
@2000
18
FF 80 49 FF 81 84 FF 82 00 FF 83 C5 FF 84 FF FF 85 3B
FF 86 00 FF 88 00 FF 89 00 FF 8B 00 FF 8C 5A C0 12 A7
FF 8E A7 FF FF 1F FF 8F 1F FF 90 E1 FF 0F 00 FF 91 77
FF FD 01 FF FC 3E FF 92 B1 FF FD 01 FF FC 3E FF 93 B2

// ==== filelist.f ====
design/cpu_pkg.sv
design/cpu_alu.sv
design/cpu_microcode.sv
design/interrupt_ctrl.sv
design/cpu_core.sv
design/gb_cpu_top.sv
verification/gb_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run from the project root, exit status is the test result
verilator --binary --timing -Wno-fatal --top-module gb_cpu_tb -f filelist.f \
  && ./obj_dir/Vgb_cpu_tb \
  || exit 1

// ==== verification/gb_cpu_tb.sv ====
`timescale 1ns/1ps

module gb_cpu_tb
  import cpu_pkg::*;
();

  localparam int TRIG_BASE = 'h1000;  // Count, then {write count, irq mask} pairs
  localparam int EXP_BASE = 'h2000;   // Count, then {addr hi, addr lo, data} triples
  localparam int SETTLE_CYCLES = 200;

  logic                 clk;
  logic                 reset;
  logic [15:0]          addr;
  logic [7:0]           wdata;
  logic                 read_en;
  logic                 write_en;
  logic [7:0]           rdata;
  logic [IRQ_COUNT-1:0] irq_req;
  logic                 boundary;

  logic [7:0] mem [65536];
  int         n_exp;
  int         wr_count;
  int         n_boundary;
  logic       write_seen;     // write_en as seen at the last falling edge
  logic       boundary_seen;  // instr_boundary at the last falling edge
  logic       read_seen;      // read_en at the last falling edge

  gb_cpu_top gb_cpu_top_inst (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .wdata          (wdata),
    .read_en        (read_en),
    .write_en       (write_en),
    .rdata          (rdata),
    .irq_req        (irq_req),
    .instr_boundary (boundary)
  );

  always #2 clk = ~clk;

  assign rdata = mem[addr];  // Zero wait state memory

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_addr(input string name, input logic [15:0] exp, input logic [15:0] got);
    if (got !== exp) abort_run($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
  endtask

  task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) abort_run($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    if (got !== exp) abort_run($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
  endtask

  // Check one bus write against the next entry of the list, then store it
  task automatic record_write();
    int base;
    logic [15:0] exp_addr;
    logic [7:0] exp_data;
    if (wr_count >= n_exp) begin
      abort_run($sformatf("unexpected extra write to %h after all %0d expected writes",
                          addr, n_exp));
    end else begin
      base = EXP_BASE + 1 + 3 * wr_count;
      exp_addr = {mem[base], mem[base + 1]};
      exp_data = mem[base + 2];
      compare_addr("addr", exp_addr, addr);
      compare_byte("wdata", exp_data, wdata);
      mem[addr] = wdata;
      wr_count++;
    end
  endtask

  always @(negedge clk) begin
    if (!reset && write_en && !write_seen) record_write();
    write_seen = write_en;
  end

  // Every instruction ends with its opcode fetch, so a boundary pulse
  // lasts one clock and comes just as that read ends
  always @(negedge clk) begin
    if (!reset && boundary) begin
      if (boundary_seen) begin
        abort_run("instr_boundary stayed high for more than one clock");
      end else if (!read_seen || read_en) begin
        abort_run("instr_boundary did not come at the end of an opcode fetch");
      end else begin
        n_boundary++;
      end
    end
    boundary_seen = boundary;
    read_seen = read_en;
  end

  // Pulse each request mask once its number of writes is reached
  initial begin : irq_stimulus
    int n_trig;
    int count;
    int idle;
    logic [IRQ_COUNT-1:0] mask;
    void'($urandom(80));
    @(negedge reset);
    n_trig = int'(mem[TRIG_BASE]);
    for (int t = 0; t < n_trig; t++) begin
      count = int'(mem[TRIG_BASE + 1 + 2 * t]);
      mask = mem[TRIG_BASE + 2 + 2 * t][IRQ_COUNT-1:0];
      while (wr_count < count) @(posedge clk);
      idle = $urandom % 16;  // Extra spin time while the CPU sits in its JR loop
      @(negedge clk);
      repeat (idle) @(negedge clk);
      irq_req = mask;
      @(negedge clk);
      irq_req = '0;
    end
  end

  initial begin : watchdog
    @(negedge reset);
    repeat (n_exp * 40 + 2000) @(posedge clk);
    abort_run($sformatf("timeout, only %0d of %0d expected writes seen", wr_count, n_exp));
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    irq_req = '0;
    wr_count = 0;
    n_boundary = 0;
    write_seen = 1'b0;
    boundary_seen = 1'b0;
    read_seen = 1'b0;
    for (int i = 0; i < 65536; i++) mem[i] = 8'(i >> 8) ^ 8'(i);
    $readmemh("verification/gb_cpu_patterns.mem", mem);
    n_exp = int'(mem[EXP_BASE]);

    repeat (4) begin
      @(negedge clk);
      compare_bit("read_en", 1'b0, read_en);
      compare_bit("write_en", 1'b0, write_en);
      compare_bit("instr_boundary", 1'b0, boundary);
    end
    reset = 1'b0;

    while (!read_en) @(negedge clk);
    compare_addr("addr", 16'h0000, addr);  // First opcode fetch

    while (wr_count < n_exp) @(posedge clk);
    repeat (SETTLE_CYCLES) @(posedge clk);  // Room for stray writes to show up
    if (n_boundary < n_exp) begin
      abort_run($sformatf("only %0d instruction boundaries seen for %0d writes",
                          n_boundary, n_exp));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== design/gb_cpu_top.sv ====
`timescale 1ns/1ps

module gb_cpu_top
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  output logic [15:0]          addr,
  output logic [7:0]           wdata,
  output logic                 read_en,
  output logic                 write_en,
  input  logic [7:0]           rdata,
  input  logic [IRQ_COUNT-1:0] irq_req,
  output logic                 instr_boundary
);

  logic [IRQ_COUNT-1:0] pending, irq_ack;
  logic                 irq_sel;
  logic [7:0]           irq_rdata;
  control_word_t        ctrl;
  logic [7:0]           opcode;
  logic                 irq_entry;
  logic [2:0]           irq_index;
  alu_op_t              alu_op;
  logic [7:0]           alu_a, alu_b, alu_result;
  logic [3:0]           flags_in, flags_out;
  cond_t                cond;
  logic                 cond_true;

  cpu_core cpu_core_inst (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .wdata          (wdata),
    .read_en        (read_en),
    .write_en       (write_en),
    .rdata          (rdata),
    .irq_sel        (irq_sel),
    .irq_rdata      (irq_rdata),
    .pending        (pending),
    .irq_ack        (irq_ack),
    .instr_boundary (instr_boundary),
    .ctrl           (ctrl),
    .opcode         (opcode),
    .irq_entry      (irq_entry),
    .irq_index      (irq_index),
    .alu_op         (alu_op),
    .alu_a          (alu_a),
    .alu_b          (alu_b),
    .flags_in       (flags_in),
    .cond           (cond),
    .alu_result     (alu_result),
    .flags_out      (flags_out),
    .cond_true      (cond_true)
  );

  cpu_microcode cpu_microcode_inst (
    .opcode    (opcode),
    .irq_entry (irq_entry),
    .irq_index (irq_index),
    .ctrl      (ctrl)
  );

  cpu_alu cpu_alu_inst (
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .flags_in   (flags_in),
    .cond       (cond),
    .alu_result (alu_result),
    .flags_out  (flags_out),
    .cond_true  (cond_true)
  );

  interrupt_ctrl interrupt_ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .wdata     (wdata),
    .read_en   (read_en),
    .write_en  (write_en),
    .irq_req   (irq_req),
    .irq_ack   (irq_ack),
    .pending   (pending),
    .irq_sel   (irq_sel),
    .irq_rdata (irq_rdata)
  );

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  output logic [15:0]          addr,
  output logic [7:0]           wdata,
  output logic                 read_en,
  output logic                 write_en,
  input  logic [7:0]           rdata,
  input  logic                 irq_sel,
  input  logic [7:0]           irq_rdata,
  input  logic [IRQ_COUNT-1:0] pending,
  output logic [IRQ_COUNT-1:0] irq_ack,
  output logic                 instr_boundary,
  input  control_word_t        ctrl,
  output logic [7:0]           opcode,
  output logic                 irq_entry,
  output logic [2:0]           irq_index,
  output alu_op_t              alu_op,
  output logic [7:0]           alu_a,
  output logic [7:0]           alu_b,
  output logic [3:0]           flags_in,
  output cond_t                cond,
  input  logic [7:0]           alu_result,
  input  logic [3:0]           flags_out,
  input  logic                 cond_true
);

  t_phase_t      phase;
  logic [2:0]    cycle_count;
  control_word_t cword;
  cycle_word_t   cur;
  logic [15:0]   pc, sp;
  logic [3:0]    f;
  logic          ime, ime_eff;
  logic [2:0]    irq_num;      // Index being served, picks the vector
  logic [7:0]    rf [10];      // B..L, IR, A, Z, W
  logic [15:0]   pair, idu_out;
  logic          last_cycle;

  function automatic logic [7:0] reg_read(reg_sel_t sel);
    case (sel)
      REG_PCH: return pc[15:8];
      REG_PCL: return pc[7:0];
      default: return rf[sel];
    endcase
  endfunction

  assign cur = cword.cycles[cycle_count];
  assign last_cycle = (cycle_count + 3'd1 == cword.num_cycles);
  assign opcode = rf[REG_IR];
  assign alu_op = cur.alu_op;
  assign flags_in = f;
  assign cond = cur.cond;

  always_comb begin
    case (cur.addr_src)
      ADDR_PC:   pair = pc;
      ADDR_SP:   pair = sp;
      ADDR_HL:   pair = {rf[REG_H], rf[REG_L]};
      ADDR_WZ:   pair = {rf[REG_W], rf[REG_Z]};
      ADDR_FF_Z: pair = {8'hFF, rf[REG_Z]};
      default:   pair = 16'h0000;
    endcase
    case (cur.idu_op)
      IDU_INC: idu_out = pair + 16'd1;
      IDU_DEC: idu_out = pair - 16'd1;
      default: idu_out = pair;
    endcase
    alu_a = reg_read(cur.alu_dst);
    alu_b = reg_read(cur.alu_src);
  end

  // IME as it stands after this cycle's misc step
  always_comb begin
    case (cur.misc_op)
      MISC_DI:           ime_eff = 1'b0;
      MISC_EI, MISC_RETI: ime_eff = 1'b1;
      default:           ime_eff = ime;
    endcase
    irq_index = '0;
    for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) irq_index = 3'(i);  // Lowest index wins
    end
    irq_entry = ime_eff && (pending != '0);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= T1;
      cycle_count <= '0;
      cword <= nop_word();  // First fetch from 0000
      pc <= 16'h0000;
      sp <= 16'hFFFE;
      f <= '0;
      ime <= 1'b0;
      irq_num <= '0;
      read_en <= 1'b0;
      write_en <= 1'b0;
      irq_ack <= '0;
      instr_boundary <= 1'b0;
    end else begin
      irq_ack <= '0;
      instr_boundary <= 1'b0;
      case (phase)
        T1: phase <= T2;
        T2: begin
          read_en <= (cur.bus_op == BUS_READ);
          write_en <= (cur.bus_op == BUS_WRITE);
          phase <= T3;
        end
        T3: phase <= T4;
        T4: begin
          phase <= T1;
          read_en <= 1'b0;
          write_en <= 1'b0;
          f <= flags_out;
          ime <= ime_eff;
          if (cur.idu_op != IDU_NONE) begin
            if (cur.addr_src == ADDR_PC) pc <= idu_out;
            if (cur.addr_src == ADDR_SP) sp <= idu_out;
          end
          case (cur.misc_op)
            MISC_JUMP_WZ, MISC_RETI: pc <= {rf[REG_W], rf[REG_Z]};
            MISC_JR_ADD: pc <= pc + {{8{rf[REG_Z][7]}}, rf[REG_Z]};
            MISC_VECTOR: pc <= irq_vector(irq_num);
            default: ;
          endcase

          if (cur.misc_op == MISC_COND_CHECK && !cond_true) begin
            cycle_count <= cword.num_cycles - 3'd1;  // Straight to the fetch
          end else if (last_cycle) begin
            cycle_count <= '0;
            cword <= ctrl;  // Decoded from the IR just fetched
            if (irq_entry) begin
              irq_ack[irq_index] <= 1'b1;
              irq_num <= irq_index;
              ime <= 1'b0;
            end else begin
              instr_boundary <= 1'b1;
            end
          end else begin
            cycle_count <= cycle_count + 3'd1;
          end
        end
        default: phase <= T1;
      endcase
    end
  end

  // Bus payload and the 8-bit register file
  always_ff @(posedge clk) begin
    if (phase == T1) addr <= pair;
    if (phase == T2) wdata <= reg_read(cur.data_reg);
    if (phase == T3 && cur.bus_op == BUS_READ && cur.data_reg < REG_PCH) begin
      rf[cur.data_reg] <= irq_sel ? irq_rdata : rdata;
    end
    if (phase == T4) begin
      if (cur.alu_op != ALU_NONE && cur.alu_dst < REG_PCH) rf[cur.alu_dst] <= alu_result;
      if (cur.idu_op != IDU_NONE && cur.addr_src == ADDR_HL) begin
        {rf[REG_H], rf[REG_L]} <= idu_out;
      end
      if (cur.idu_op != IDU_NONE && cur.addr_src == ADDR_WZ) begin
        {rf[REG_W], rf[REG_Z]} <= idu_out;
      end
    end
  end

endmodule

// ==== design/interrupt_ctrl.sv ====
`timescale 1ns/1ps

module interrupt_ctrl
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [15:0]          addr,
  input  logic [7:0]           wdata,
  input  logic                 read_en,
  input  logic                 write_en,
  input  logic [IRQ_COUNT-1:0] irq_req,
  input  logic [IRQ_COUNT-1:0] irq_ack,
  output logic [IRQ_COUNT-1:0] pending,
  output logic                 irq_sel,
  output logic [7:0]           irq_rdata
);

  logic [7:0] if_reg, ie_reg;
  logic write_q;
  logic write_stb;
  logic [IRQ_COUNT-1:0] if_bits;

  assign write_stb = write_en && !write_q;  // One write per bus cycle

  always_comb begin
    if_bits = if_reg[IRQ_COUNT-1:0];
    if (write_stb && addr == IF_ADDR) if_bits = wdata[IRQ_COUNT-1:0];
    if_bits = (if_bits & ~irq_ack) | irq_req;  // New requests beat the ack
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_reg <= 8'hE0;
      ie_reg <= 8'h00;
      write_q <= 1'b0;
    end else begin
      write_q <= write_en;
      if_reg <= {{(8 - IRQ_COUNT){1'b1}}, if_bits};  // Unused bits read as 1
      if (write_stb && addr == IE_ADDR) ie_reg <= wdata;
    end
  end

  assign pending = if_reg[IRQ_COUNT-1:0] & ie_reg[IRQ_COUNT-1:0];
  assign irq_sel = read_en && (addr == IF_ADDR || addr == IE_ADDR);
  assign irq_rdata = (addr == IF_ADDR) ? if_reg : ie_reg;

endmodule

// ==== design/cpu_microcode.sv ====
`timescale 1ns/1ps

module cpu_microcode
  import cpu_pkg::*;
(
  input  logic [7:0]    opcode,
  input  logic          irq_entry,
  input  logic [2:0]    irq_index,
  output control_word_t ctrl
);

  always_comb begin
    cycle_word_t c;
    alu_op_t op;
    ctrl = nop_word();  // Anything outside the subset runs as NOP
    c = cyc_fetch();
    op = ALU_NONE;

    if (irq_entry) begin
      if (irq_index < IRQ_COUNT) begin
        ctrl.num_cycles = 3'd5;
        ctrl.cycles[0] = cyc_idu(ADDR_PC, IDU_DEC);  // Undo the discarded fetch
        ctrl.cycles[1] = cyc_idu(ADDR_SP, IDU_DEC);
        ctrl.cycles[2] = cyc_write(ADDR_SP, REG_PCH, IDU_DEC);
        c = cyc_write(ADDR_SP, REG_PCL, IDU_NONE);
        c.misc_op = MISC_VECTOR;  // PC ready before the final fetch
        ctrl.cycles[3] = c;
        ctrl.cycles[4] = cyc_fetch();
      end
    end else begin
      casez (opcode)
        8'h18: begin  // JR e8
          ctrl.num_cycles = 3'd3;
          ctrl.cycles[0] = cyc_read(ADDR_PC, REG_Z, IDU_INC);
          ctrl.cycles[1] = cyc_misc(MISC_JR_ADD);
          ctrl.cycles[2] = cyc_fetch();
        end
        8'h20, 8'h28, 8'h30, 8'h38: begin  // JR cc,e8
          c = cyc_read(ADDR_PC, REG_Z, IDU_INC);
          c.misc_op = MISC_COND_CHECK;
          c.cond = cond_t'(opcode[4:3]);
          ctrl.num_cycles = 3'd3;
          ctrl.cycles[0] = c;
          ctrl.cycles[1] = cyc_misc(MISC_JR_ADD);
          ctrl.cycles[2] = cyc_fetch();
        end
        8'h77: begin  // LD (HL),A
          ctrl.num_cycles = 3'd2;
          ctrl.cycles[0] = cyc_write(ADDR_HL, REG_A, IDU_NONE);
          ctrl.cycles[1] = cyc_fetch();
        end
        8'h7E: begin  // LD A,(HL)
          ctrl.num_cycles = 3'd2;
          ctrl.cycles[0] = cyc_read(ADDR_HL, REG_A, IDU_NONE);
          ctrl.cycles[1] = cyc_fetch();
        end
        8'hC3: begin  // JP a16
          ctrl.num_cycles = 3'd4;
          ctrl.cycles[0] = cyc_read(ADDR_PC, REG_Z, IDU_INC);
          ctrl.cycles[1] = cyc_read(ADDR_PC, REG_W, IDU_INC);
          ctrl.cycles[2] = cyc_misc(MISC_JUMP_WZ);
          ctrl.cycles[3] = cyc_fetch();
        end
        8'hD9: begin  // RETI pops PCL then PCH
          ctrl.num_cycles = 3'd4;
          ctrl.cycles[0] = cyc_read(ADDR_SP, REG_Z, IDU_INC);
          ctrl.cycles[1] = cyc_read(ADDR_SP, REG_W, IDU_INC);
          ctrl.cycles[2] = cyc_misc(MISC_RETI);
          ctrl.cycles[3] = cyc_fetch();
        end
        8'hE0: begin  // LDH (n8),A
          ctrl.num_cycles = 3'd3;
          ctrl.cycles[0] = cyc_read(ADDR_PC, REG_Z, IDU_INC);
          ctrl.cycles[1] = cyc_write(ADDR_FF_Z, REG_A, IDU_NONE);
          ctrl.cycles[2] = cyc_fetch();
        end
        8'hF0: begin  // LDH A,(n8)
          ctrl.num_cycles = 3'd3;
          ctrl.cycles[0] = cyc_read(ADDR_PC, REG_Z, IDU_INC);
          ctrl.cycles[1] = cyc_read(ADDR_FF_Z, REG_A, IDU_NONE);
          ctrl.cycles[2] = cyc_fetch();
        end
        8'hF3, 8'hFB: begin
          c.misc_op = opcode[3] ? MISC_EI : MISC_DI;
          ctrl.cycles[0] = c;
        end
        8'b00???110: begin  // LD r,n8
          if (opcode[5:3] != 3'b110) begin
            ctrl.num_cycles = 3'd2;
            ctrl.cycles[0] = cyc_read(ADDR_PC, op_reg(opcode[5:3]), IDU_INC);
            ctrl.cycles[1] = cyc_fetch();
          end
        end
        8'b00???100: begin  // INC r overlaps the fetch
          if (opcode[5:3] != 3'b110) begin
            c.alu_op = ALU_INC;
            c.alu_dst = op_reg(opcode[5:3]);
            c.alu_src = op_reg(opcode[5:3]);
            ctrl.cycles[0] = c;
          end
        end
        8'b10??????: begin
          case (opcode[5:3])
            3'b000:  op = ALU_ADD;
            3'b010:  op = ALU_SUB;
            3'b100:  op = ALU_AND;
            3'b101:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            default: op = ALU_NONE;  // ADC, SBC and CP not kept
          endcase
          if (op != ALU_NONE && opcode[2:0] != 3'b110) begin
            c.alu_op = op;
            c.alu_dst = REG_A;
            c.alu_src = op_reg(opcode[2:0]);
            ctrl.cycles[0] = c;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== design/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu
  import cpu_pkg::*;
(
  input  alu_op_t    alu_op,
  input  logic [7:0] alu_a,
  input  logic [7:0] alu_b,
  input  logic [3:0] flags_in,   // {Z, N, H, C}
  input  cond_t      cond,
  output logic [7:0] alu_result,
  output logic [3:0] flags_out,
  output logic       cond_true
);

  logic [8:0] wide;
  logic [4:0] nib;
  logic z, n, h, c;

  always_comb begin
    wide = '0;
    nib = '0;
    alu_result = alu_a;
    n = 1'b0;
    h = flags_in[1];
    c = flags_in[0];
    case (alu_op)
      ALU_ADD: begin
        wide = {1'b0, alu_a} + {1'b0, alu_b};
        nib = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]};
        alu_result = wide[7:0];
        h = nib[4];
        c = wide[8];
      end
      ALU_SUB: begin
        wide = {1'b0, alu_a} - {1'b0, alu_b};  // Bit 8 is the borrow
        nib = {1'b0, alu_a[3:0]} - {1'b0, alu_b[3:0]};
        alu_result = wide[7:0];
        n = 1'b1;
        h = nib[4];
        c = wide[8];
      end
      ALU_AND: begin
        alu_result = alu_a & alu_b;
        h = 1'b1;
        c = 1'b0;
      end
      ALU_OR: begin
        alu_result = alu_a | alu_b;
        h = 1'b0;
        c = 1'b0;
      end
      ALU_XOR: begin
        alu_result = alu_a ^ alu_b;
        h = 1'b0;
        c = 1'b0;
      end
      ALU_INC: begin
        nib = {1'b0, alu_a[3:0]} + 5'd1;
        alu_result = alu_a + 8'd1;
        h = nib[4];  // Carry stays as it was
      end
      ALU_PASS: alu_result = alu_b;
      default: ;
    endcase
    z = (alu_result == 8'h00);
    if (alu_op inside {ALU_NONE, ALU_PASS}) flags_out = flags_in;
    else flags_out = {z, n, h, c};
  end

  always_comb begin
    case (cond)
      COND_NZ: cond_true = !flags_in[3];
      COND_Z:  cond_true = flags_in[3];
      COND_NC: cond_true = !flags_in[0];
      default: cond_true = flags_in[0];
    endcase
  end

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  localparam int MAX_CYCLES = 5;
  localparam int IRQ_COUNT = 5;
  localparam logic [15:0] IF_ADDR = 16'hFF0F;
  localparam logic [15:0] IE_ADDR = 16'hFFFF;

  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  typedef enum logic [2:0] {
    ADDR_NONE, ADDR_PC, ADDR_SP, ADDR_HL, ADDR_WZ, ADDR_FF_Z
  } addr_src_t;

  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;

  // B..L and A follow the r field of the opcode, slot 6 holds IR
  typedef enum logic [3:0] {
    REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_IR, REG_A,
    REG_Z, REG_W, REG_PCH, REG_PCL
  } reg_sel_t;

  typedef enum logic [2:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_INC, ALU_PASS
  } alu_op_t;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

  typedef enum logic [2:0] {
    MISC_NONE, MISC_JUMP_WZ, MISC_JR_ADD, MISC_COND_CHECK,
    MISC_EI, MISC_DI, MISC_RETI, MISC_VECTOR
  } misc_op_t;

  typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

  typedef struct packed {
    addr_src_t addr_src;
    idu_op_t   idu_op;
    bus_op_t   bus_op;
    reg_sel_t  data_reg;  // Filled by a read, sourced by a write
    alu_op_t   alu_op;
    reg_sel_t  alu_dst;
    reg_sel_t  alu_src;
    misc_op_t  misc_op;
    cond_t     cond;
  } cycle_word_t;

  typedef struct packed {
    logic [2:0] num_cycles;
    cycle_word_t [MAX_CYCLES-1:0] cycles;
  } control_word_t;

  // Internal cycle, only the IDU works on a pair
  function automatic cycle_word_t cyc_idu(addr_src_t src, idu_op_t op);
    cycle_word_t c;
    c = '0;
    c.addr_src = src;
    c.idu_op = op;
    return c;
  endfunction

  function automatic cycle_word_t cyc_read(addr_src_t src, reg_sel_t dst, idu_op_t op);
    cycle_word_t c;
    c = cyc_idu(src, op);
    c.bus_op = BUS_READ;
    c.data_reg = dst;
    return c;
  endfunction

  function automatic cycle_word_t cyc_write(addr_src_t src, reg_sel_t data, idu_op_t op);
    cycle_word_t c;
    c = cyc_idu(src, op);
    c.bus_op = BUS_WRITE;
    c.data_reg = data;
    return c;
  endfunction

  function automatic cycle_word_t cyc_misc(misc_op_t op);
    cycle_word_t c;
    c = '0;
    c.misc_op = op;
    return c;
  endfunction

  // Opcode fetch closes every instruction
  function automatic cycle_word_t cyc_fetch();
    return cyc_read(ADDR_PC, REG_IR, IDU_INC);
  endfunction

  function automatic control_word_t nop_word();
    control_word_t w;
    w = '0;
    w.num_cycles = 3'd1;
    w.cycles[0] = cyc_fetch();
    return w;
  endfunction

  function automatic reg_sel_t op_reg(logic [2:0] field);
    return reg_sel_t'({1'b0, field});
  endfunction

  function automatic logic [15:0] irq_vector(logic [2:0] idx);
    return {8'h00, 2'b01, idx, 3'b000};  // 0x40 + 8 * idx
  endfunction

endpackage
